// File: hw/boot_rom.sv
/*
 * Boot ROM
 *   constant image from the package, registered read port
 */

`timescale 1ns/1ps

module boot_rom (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                sel_i,
  input  harness_pkg::addr_t  addr_i,
  output harness_pkg::data_t  rdata_o
);

  import harness_pkg::*;

  addr_u                  addr;
  logic [RomIdxWidth-1:0] rom_idx;
  logic                   in_image;
  data_t                  rom_word;
  data_t                  rdata_q;

  assign addr.raw = addr_i;
  assign rom_idx  = addr.fields.word[RomIdxWidth-1:0];
  assign in_image = (addr.fields.word < RomWords);  // Rest of the window reads zero

  assign rom_word = in_image ? rom_image[rom_idx] : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (sel_i) begin
      rdata_q <= rom_word;
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: hw/bus_decoder.sv
/*
 * Address decoder of the harness bus
 *   region decode and select strobes to ROM and DRAM
 *   one-entry response pipeline with error answer
 *   read data return by registered region
 */

`timescale 1ns/1ps

module bus_decoder (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_i,
  input  logic                we_i,
  input  harness_pkg::addr_t  addr_i,
  output logic                rsp_valid_o,
  output logic                rsp_err_o,
  output harness_pkg::data_t  rdata_o,
  output logic                rom_sel_o,
  output logic                dram_sel_o,
  input  harness_pkg::data_t  rom_rdata_i,
  input  harness_pkg::data_t  dram_rdata_i
);

  import harness_pkg::*;

  addr_u   addr;
  region_e region;
  logic    err;

  logic    rsp_valid_q;
  region_e region_q;
  logic    err_q;
  logic    we_q;

  assign addr.raw = addr_i;

  // --------------------------------------------------------------------------
  // Request side, same cycle
  // --------------------------------------------------------------------------
  always_comb begin
    region = RegionNone;
    if ((addr.raw >= RomBase) && (addr.raw < RomBase + RomLength)) begin
      region = RegionRom;
    end else if ((addr.raw >= GpioBase) && (addr.raw < GpioBase + GpioLength)) begin
      region = RegionGpio;
    end else if ((addr.raw >= DramBase) && (addr.raw < DramBase + DramLength)) begin
      region = RegionDram;
    end
  end

  // ROM is read only, GPIO has no device behind it
  always_comb begin
    unique case (region)
      RegionRom:  err = we_i;
      RegionDram: err = 1'b0;
      default:    err = 1'b1;
    endcase
  end

  assign rom_sel_o  = req_i && (region == RegionRom) && !we_i;
  assign dram_sel_o = req_i && (region == RegionDram);

  // --------------------------------------------------------------------------
  // Response side, one cycle later
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
      region_q    <= RegionNone;
      err_q       <= 1'b0;
      we_q        <= 1'b0;
    end else begin
      rsp_valid_q <= req_i;
      if (req_i) begin
        region_q <= region;
        err_q    <= err;
        we_q     <= we_i;
      end
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_err_o   = rsp_valid_q && err_q;

  // Writes and errors return zero
  always_comb begin
    rdata_o = '0;
    if (rsp_valid_q && !err_q && !we_q) begin
      unique case (region_q)
        RegionRom:  rdata_o = rom_rdata_i;
        RegionDram: rdata_o = dram_rdata_i;
        default:    rdata_o = '0;
      endcase
    end
  end

endmodule

// File: hw/debug_ctrl.sv
/*
 * Debug control
 *   post-reset delay window and enable gating of debug requests
 *   non-debug reset with synchronized release
 */

`timescale 1ns/1ps

module debug_ctrl (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            ndmreset_req_i,
  input  logic                            debug_enable_i,
  input  logic [harness_pkg::NbHarts-1:0] debug_req_i,
  output logic [harness_pkg::NbHarts-1:0] debug_req_o,
  output logic                            ndmreset_no
);

  import harness_pkg::*;

  logic [DmiCntWidth-1:0] del_cnt_q;
  logic                   del_active;

  logic                   sync_rst_n;
  logic [1:0]             sync_q;

  // --------------------------------------------------------------------------
  // Delay window, lets boot code run before the first debug halt
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      del_cnt_q <= DmiCntWidth'(DmiDelCycles);
    end else if (del_cnt_q != '0) begin
      del_cnt_q <= del_cnt_q - 1'b1;
    end
  end

  assign del_active = (del_cnt_q != '0);

  // Pass-through once the window has closed
  assign debug_req_o = (del_active || !debug_enable_i) ? '0 : debug_req_i;

  // --------------------------------------------------------------------------
  // Non-debug reset
  // --------------------------------------------------------------------------
  // Asserts at once on either source, releases after two edges
  assign sync_rst_n = rst_ni && !ndmreset_req_i;

  always_ff @(posedge clk_i or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign ndmreset_no = sync_q[1];

endmodule

// File: hw/dram_mem.sv
/*
 * Main memory model
 *   word array with byte enables, registered read
 *   exit-code mailbox at a fixed DRAM address
 */

`timescale 1ns/1ps

module dram_mem (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                sel_i,
  input  logic                we_i,
  input  harness_pkg::addr_t  addr_i,
  input  harness_pkg::be_t    be_i,
  input  harness_pkg::data_t  wdata_i,
  output harness_pkg::data_t  rdata_o,
  output logic [31:0]         exit_o
);

  import harness_pkg::*;

  data_t       mem [DramWords];
  addr_u       addr;
  logic [12:0] word_idx;
  logic        wr_en;
  logic        exit_hit;

  data_t       rdata_q;
  logic [31:0] exit_q;

  assign addr.raw = addr_i;
  assign word_idx = addr.fields.word;
  assign wr_en    = sel_i && we_i;
  assign exit_hit = wr_en && (addr.raw == ExitAddr);

  // --------------------------------------------------------------------------
  // Storage, contents survive every reset
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int b = 0; b < BeWidth; b++) begin
        if (be_i[b]) begin
          mem[word_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Read port, holds between reads
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (sel_i && !we_i) begin
      rdata_q <= mem[word_idx];
    end
  end

  // --------------------------------------------------------------------------
  // Exit mailbox
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exit_q <= '0;
    end else if (exit_hit) begin
      exit_q <= wdata_i[31:0];  // Byte enables ignored here
    end
  end

  assign rdata_o = rdata_q;
  assign exit_o  = exit_q;

endmodule

// File: hw/harness_pkg.sv
/*
 * Shared definitions of the memory harness
 *   bus widths and the vector types built on them
 *   address map of boot ROM, GPIO and DRAM, exit mailbox
 *   debug request delay window
 *   boot ROM image, region type and the two-way address union
 */

package harness_pkg;

  // --------------------------------------------------------------------------
  // Bus widths
  // --------------------------------------------------------------------------
  localparam int unsigned AddrWidth = 64;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned BeWidth   = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   be_t;

  // Debug request lines and the post-reset quiet window
  localparam int unsigned NbHarts      = 2;
  localparam int unsigned DmiDelCycles = 64;
  localparam int unsigned DmiCntWidth  = $clog2(DmiDelCycles + 1);

  // --------------------------------------------------------------------------
  // Address map
  // --------------------------------------------------------------------------
  localparam addr_t RomBase    = 64'h0000_0000_0001_0000;
  localparam addr_t RomLength  = 64'h0000_0000_0001_0000;
  localparam addr_t GpioBase   = 64'h0000_0000_4000_0000;
  localparam addr_t GpioLength = 64'h0000_0000_0000_1000;
  localparam addr_t DramBase   = 64'h0000_0000_8000_0000;
  localparam addr_t DramLength = 64'h0000_0000_0001_0000;  // 64 KiB
  localparam addr_t ExitAddr   = 64'h0000_0000_8000_1000;  // Inside DRAM

  localparam int unsigned DramWords   = 8192;
  localparam int unsigned RomWords    = 16;
  localparam int unsigned RomIdxWidth = $clog2(RomWords);

  // Boot image, two instructions per word, unused tail is zero
  localparam data_t rom_image [RomWords] = '{
    64'h0010_0293_f140_2573,  // csrr a0, mhartid ; li t0, 1
    64'h01f2_9293_0000_0597,  // auipc a1, 0 ; slli t0, t0, 31
    64'h0000_0013_0002_8067,  // jr t0 ; nop
    64'h0000_0013_0000_0013,
    64'h1050_0073_0000_0013,  // Park loop
    64'hffdf_f06f_0000_0013,
    64'h0000_0000_0000_0000,
    64'h0000_0000_0000_0000,
    64'hd00d_feed_0000_0040,  // Device tree stub
    64'h0000_0000_0000_0038,
    64'h0000_0011_0000_0048,
    64'h0000_0000_0000_0010,
    64'h0000_0000_0000_0000,
    64'h0000_0000_0000_0000,
    64'h0000_0000_0000_0000,
    64'h0000_0000_0000_0000
  };

  // --------------------------------------------------------------------------
  // Decode types
  // --------------------------------------------------------------------------
  typedef enum logic [1:0] {
    RegionNone,
    RegionRom,
    RegionGpio,
    RegionDram
  } region_e;

  typedef struct packed {
    logic [47:0] tag;     // Above the 64 KiB windows
    logic [12:0] word;    // 64-bit word index
    logic [2:0]  offset;  // Byte within the word
  } addr_fields_t;

  // Window compare uses raw, memories use fields
  typedef union packed {
    addr_t        raw;
    addr_fields_t fields;
  } addr_u;

endpackage

// File: hw/soc_harness.sv
/*
 * Top level of the memory harness
 *   bus decoder, boot ROM, DRAM with exit mailbox, debug control
 */

`timescale 1ns/1ps

module soc_harness (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // Request strobe
  input  logic                            req_i,
  input  logic                            we_i,
  input  harness_pkg::addr_t              addr_i,
  input  harness_pkg::be_t                be_i,
  input  harness_pkg::data_t              wdata_i,
  // Response strobe
  output logic                            rsp_valid_o,
  output logic                            rsp_err_o,
  output harness_pkg::data_t              rdata_o,
  output logic [31:0]                     exit_o,
  // Debug
  input  logic [harness_pkg::NbHarts-1:0] debug_req_i,
  input  logic                            debug_enable_i,
  input  logic                            ndmreset_req_i,
  output logic [harness_pkg::NbHarts-1:0] debug_req_o
);

  import harness_pkg::*;

  logic  ndmreset_n;   // Resets everything except debug_ctrl
  logic  rom_sel;
  logic  dram_sel;
  data_t rom_rdata;
  data_t dram_rdata;

  // --------------------------------------------------------------------------
  // Debug and reset
  // --------------------------------------------------------------------------
  debug_ctrl i_debug_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),  // Power-on reset only
    .ndmreset_req_i ( ndmreset_req_i ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_i    ( debug_req_i    ),
    .debug_req_o    ( debug_req_o    ),
    .ndmreset_no    ( ndmreset_n     )
  );

  // --------------------------------------------------------------------------
  // Bus and memories
  // --------------------------------------------------------------------------
  bus_decoder i_bus_decoder (
    .clk_i        ( clk_i       ),
    .rst_ni       ( ndmreset_n  ),
    .req_i        ( req_i       ),
    .we_i         ( we_i        ),
    .addr_i       ( addr_i      ),
    .rsp_valid_o  ( rsp_valid_o ),
    .rsp_err_o    ( rsp_err_o   ),
    .rdata_o      ( rdata_o     ),
    .rom_sel_o    ( rom_sel     ),
    .dram_sel_o   ( dram_sel    ),
    .rom_rdata_i  ( rom_rdata   ),
    .dram_rdata_i ( dram_rdata  )
  );

  boot_rom i_boot_rom (
    .clk_i   ( clk_i      ),
    .rst_ni  ( ndmreset_n ),
    .sel_i   ( rom_sel    ),
    .addr_i  ( addr_i     ),
    .rdata_o ( rom_rdata  )
  );

  dram_mem i_dram_mem (
    .clk_i   ( clk_i      ),
    .rst_ni  ( ndmreset_n ),
    .sel_i   ( dram_sel   ),
    .we_i    ( we_i       ),
    .addr_i  ( addr_i     ),
    .be_i    ( be_i       ),
    .wdata_i ( wdata_i    ),
    .rdata_o ( dram_rdata ),
    .exit_o  ( exit_o     )
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the harness testbench with Verilator, verdict taken from sim.log

rm -rf obj_dir sim.log

{ verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_soc_harness -o Vtb_soc_harness \
    && ./obj_dir/Vtb_soc_harness; } > sim.log 2>&1 \
  || echo "Regression failed" >> sim.log

cat sim.log

grep -q "Regression failed" sim.log && exit 1 || exit 0

// File: test/soc_harness_properties.sv
/*
 * Bound checks on the harness top level
 *   one-cycle response strobe, zero read data on errors
 *   quiet debug requests in the post-reset window
 */

`timescale 1ns/1ps

module soc_harness_properties (
  input logic                            clk_i,
  input logic                            rst_ni,
  input logic                            ndmreset_ni,
  input logic                            req_i,
  input logic                            rsp_valid_i,
  input logic                            rsp_err_i,
  input harness_pkg::data_t              rdata_i,
  input logic [harness_pkg::NbHarts-1:0] debug_req_i
);

  import harness_pkg::*;

  logic [DmiCntWidth-1:0] win_cnt_q;  // Edges since power-on reset, saturating

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      win_cnt_q <= '0;
    end else if (win_cnt_q != DmiCntWidth'(DmiDelCycles)) begin
      win_cnt_q <= win_cnt_q + 1'b1;
    end
  end

  rsp_after_req: assert property (
    @(posedge clk_i) disable iff (!ndmreset_ni) req_i |=> rsp_valid_i
  ) else $error("response strobe missing one cycle after a request");

  no_rsp_without_req: assert property (
    @(posedge clk_i) disable iff (!ndmreset_ni) !req_i |=> !rsp_valid_i
  ) else $error("response strobe without a request");

  err_zero_data: assert property (
    @(posedge clk_i) rsp_err_i |-> (rdata_i == '0)
  ) else $error("nonzero read data on an error response");

  debug_quiet: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      (win_cnt_q < DmiCntWidth'(DmiDelCycles)) |-> (debug_req_i == '0)
  ) else $error("debug request inside the post-reset window");

endmodule

bind soc_harness soc_harness_properties u_properties (
  .clk_i       ( clk_i       ),
  .rst_ni      ( rst_ni      ),
  .ndmreset_ni ( ndmreset_n  ),
  .req_i       ( req_i       ),
  .rsp_valid_i ( rsp_valid_o ),
  .rsp_err_i   ( rsp_err_o   ),
  .rdata_i     ( rdata_o     ),
  .debug_req_i ( debug_req_o )
);

// File: test/tb_soc_harness.sv
/*
 * Testbench of the memory harness
 *   clock, reset, request driver and response monitor
 *   compare tasks, directed tests, watchdog
 */

`timescale 1ns/1ps

module tb_soc_harness;

  import harness_pkg::*;

  localparam int unsigned ClkPeriod  = 8;
  localparam int unsigned TestCycles = 240;  // Sum of all directed tests, reset included
  localparam int unsigned Margin     = 100;
  localparam int unsigned NbWords    = 16;
  localparam addr_t       TestBase   = DramBase + 64'h200;

  logic               clk_i;
  logic               rst_ni;
  logic               req_i;
  logic               we_i;
  addr_t              addr_i;
  be_t                be_i;
  data_t              wdata_i;
  logic               rsp_valid_o;
  logic               rsp_err_o;
  data_t              rdata_o;
  logic [31:0]        exit_o;
  logic [NbHarts-1:0] debug_req_i;
  logic               debug_enable_i;
  logic               ndmreset_req_i;
  logic [NbHarts-1:0] debug_req_o;

  // Outstanding requests, oldest first
  data_t       exp_data_q [$];
  logic        exp_err_q [$];
  addr_t       exp_addr_q [$];
  int unsigned exp_cyc_q [$];
  int unsigned cycle_cnt = 0;
  data_t       dram_model [NbWords];  // Expected contents at TestBase

  soc_harness DUT (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .req_i          ( req_i          ),
    .we_i           ( we_i           ),
    .addr_i         ( addr_i         ),
    .be_i           ( be_i           ),
    .wdata_i        ( wdata_i        ),
    .rsp_valid_o    ( rsp_valid_o    ),
    .rsp_err_o      ( rsp_err_o      ),
    .rdata_o        ( rdata_o        ),
    .exit_o         ( exit_o         ),
    .debug_req_i    ( debug_req_i    ),
    .debug_enable_i ( debug_enable_i ),
    .ndmreset_req_i ( ndmreset_req_i ),
    .debug_req_o    ( debug_req_o    )
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic abort_run();
    $display("Regression failed");
    $fatal(1, "run stopped at %0t ns", $time);
  endtask

  task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_exit(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_debug(input logic [NbHarts-1:0] got, input logic [NbHarts-1:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  // Byte lanes of wdata replace the old word where enabled
  function automatic data_t merge_bytes(input data_t old, input data_t wdata, input be_t be);
    data_t merged;
    merged = old;
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) begin
        merged[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return merged;
  endfunction

  // --------------------------------------------------------------------------
  // Request driver and response monitor
  // --------------------------------------------------------------------------
  task automatic send_req(input logic we, input addr_t addr, input be_t be, input data_t wdata,
                          input data_t exp_data, input logic exp_err);
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= we;
    addr_i  <= addr;
    be_i    <= be;
    wdata_i <= wdata;
    exp_data_q.push_back(exp_data);
    exp_err_q.push_back(exp_err);
    exp_addr_q.push_back(addr);
    exp_cyc_q.push_back(cycle_cnt);
  endtask

  // Ends the strobe, returns in the cycle of the last response
  task automatic wait_rsp_cycle();
    @(posedge clk_i);
    req_i <= 1'b0;
    we_i  <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic drain_bus();
    wait_rsp_cycle();
    while (exp_cyc_q.size() != 0) @(negedge clk_i);
  endtask

  always @(negedge clk_i) begin : rsp_monitor
    addr_t addr;
    if (rsp_valid_o) begin
      if (exp_cyc_q.size() == 0) begin
        $display("response strobe seen at %0t ns with no request outstanding", $time);
        abort_run();
      end else begin
        addr = exp_addr_q.pop_front();
        void'(exp_cyc_q.pop_front());
        check_err(rsp_err_o, exp_err_q.pop_front(), $sformatf("error flag at %h", addr));
        check_data(rdata_o, exp_data_q.pop_front(), $sformatf("read data at %h", addr));
      end
    end else if ((exp_cyc_q.size() != 0) && (exp_cyc_q[0] + 2 <= cycle_cnt)) begin
      $display("no response one cycle after the request to %h", exp_addr_q[0]);
      abort_run();
    end
  end

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic test_debug_gating();
    for (int i = 0; i < DmiDelCycles; i++) begin
      @(negedge clk_i);
      check_debug(debug_req_o, '0, "debug request inside delay window");
    end
    @(negedge clk_i);
    check_debug(debug_req_o, '1, "debug request after delay window");
    @(posedge clk_i);
    debug_enable_i <= 1'b0;
    @(negedge clk_i);
    check_debug(debug_req_o, '0, "debug request with enable low");
    @(posedge clk_i);
    debug_enable_i <= 1'b1;
    debug_req_i    <= NbHarts'(1);  // First hart only
    @(negedge clk_i);
    check_debug(debug_req_o, NbHarts'(1), "debug request of one hart");
  endtask

  task automatic test_rom_reads();
    for (int i = 0; i < RomWords; i++) begin
      send_req(1'b0, RomBase + addr_t'(8 * i), '1, '0, rom_image[i], 1'b0);
    end
    send_req(1'b0, RomBase + addr_t'(8 * RomWords), '1, '0, '0, 1'b0);  // Past the image
    send_req(1'b0, RomBase + RomLength - 64'd8, '1, '0, '0, 1'b0);
    send_req(1'b1, RomBase, '1, {$urandom, $urandom}, '0, 1'b1);
    drain_bus();
  endtask

  task automatic test_dram_byte_enables();
    data_t wdata;
    be_t   be;
    for (int i = 0; i < NbWords; i++) begin
      wdata         = {$urandom, $urandom};
      dram_model[i] = wdata;
      send_req(1'b1, TestBase + addr_t'(8 * i), '1, wdata, '0, 1'b0);
    end
    for (int i = 0; i < NbWords; i++) begin
      wdata         = {$urandom, $urandom};
      be            = be_t'($urandom);
      dram_model[i] = merge_bytes(dram_model[i], wdata, be);
      send_req(1'b1, TestBase + addr_t'(8 * i), be, wdata, '0, 1'b0);
    end
    for (int i = 0; i < NbWords; i++) begin
      send_req(1'b0, TestBase + addr_t'(8 * i), '1, '0, dram_model[i], 1'b0);
    end
    drain_bus();
  endtask

  task automatic test_error_region();
    addr_t bad [4] = '{GpioBase, GpioBase + 64'h800, 64'h2000_0000, DramBase + DramLength};
    for (int i = 0; i < 4; i++) begin
      send_req(1'b0, bad[i], '1, '0, '0, 1'b1);
      send_req(1'b1, bad[i], '1, {$urandom, $urandom}, '0, 1'b1);
    end
    drain_bus();
  endtask

  task automatic test_exit_mailbox();
    data_t       wdata;
    logic [31:0] exit_val;
    wdata = {$urandom, $urandom};
    send_req(1'b1, ExitAddr, be_t'($urandom), wdata, '0, 1'b0);
    wait_rsp_cycle();
    check_exit(exit_o, wdata[31:0], "exit code one cycle after mailbox write");
    drain_bus();
    exit_val = wdata[31:0];
    send_req(1'b1, ExitAddr + 64'd8, '1, {$urandom, $urandom}, '0, 1'b0);
    send_req(1'b1, GpioBase, '1, {$urandom, $urandom}, '0, 1'b1);
    drain_bus();
    check_exit(exit_o, exit_val, "exit code after writes elsewhere");
  endtask

  task automatic test_ndmreset();
    data_t wdata;
    wdata = {$urandom, $urandom} | 64'h1;  // Nonzero code
    send_req(1'b1, ExitAddr, '1, wdata, '0, 1'b0);
    drain_bus();
    check_exit(exit_o, wdata[31:0], "exit code before reset pulse");
    @(posedge clk_i);
    ndmreset_req_i <= 1'b1;
    @(negedge clk_i);
    check_exit(exit_o, '0, "exit code during non-debug reset");
    @(posedge clk_i);
    ndmreset_req_i <= 1'b0;
    repeat (2) @(posedge clk_i);  // Synchronizer release
    check_exit(exit_o, '0, "exit code after non-debug reset");
    for (int i = 0; i < NbWords; i++) begin
      send_req(1'b0, TestBase + addr_t'(8 * i), '1, '0, dram_model[i], 1'b0);
    end
    drain_bus();
  endtask

  initial begin
    void'($urandom(18793));
    rst_ni         = 1'b0;
    req_i          = 1'b0;
    we_i           = 1'b0;
    addr_i         = '0;
    be_i           = '0;
    wdata_i        = '0;
    debug_req_i    = '1;
    debug_enable_i = 1'b1;
    ndmreset_req_i = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_debug_gating();  // Window starts at reset release
    test_rom_reads();
    test_dram_byte_enables();
    test_error_region();
    test_exit_mailbox();
    test_ndmreset();
    $display("Regression passed");
    $finish;
  end

  initial begin : watchdog
    #((TestCycles + Margin) * ClkPeriod);
    $display("timeout after %0d cycles, the tests did not finish", TestCycles + Margin);
    abort_run();
  end

endmodule

// File: vlog.f
hw/harness_pkg.sv
hw/bus_decoder.sv
hw/boot_rom.sv
hw/dram_mem.sv
hw/debug_ctrl.sv
hw/soc_harness.sv
test/soc_harness_properties.sv
test/tb_soc_harness.sv
